// File: common/lvdc_timing_pkg.sv
package lvdc_timing_pkg;

    // alternating memory phases, REI then RED
    typedef enum logic {
        PH_INSTR = 1'b0,
        PH_DATA  = 1'b1
    } phase_t;

    // serial module-control frame, one bit per clock
    localparam int HOP_BITS  = 10;
    localparam int HOP_CNT_W = $clog2(HOP_BITS);

    // count value of the last bit time in a frame
    localparam logic [HOP_CNT_W-1:0] HOP_LAST = HOP_CNT_W'(HOP_BITS - 1);

endpackage

// File: common/lvdc_mem_pkg.sv
package lvdc_mem_pkg;

    localparam int MOD_W   = 2;
    localparam int SECT_W  = 2;
    localparam int MOD_CNT = 1 << MOD_W;   // modules 0, 2, 4, 6

    localparam logic [SECT_W-1:0] SECT_A    = 2'b01;
    localparam logic [SECT_W-1:0] SECT_BOTH = 2'b11;

    typedef struct packed {
        logic [MOD_W-1:0]  mod;    // 0..3 -> module 0/2/4/6
        logic [SECT_W-1:0] sect;   // bit 0 sector A, bit 1 sector B
        logic              dup;    // duplex
    } mod_sel_t;

    // im occupies the upper half of the frame
    typedef struct packed {
        mod_sel_t im;
        mod_sel_t dm;
    } hop_field_t;

    localparam mod_sel_t MOD_SEL_RST = '{mod: '0, sect: SECT_A, dup: 1'b0};

    // duplex operation enables both sectors at once
    function automatic mod_sel_t apply_duplex(mod_sel_t ms);
        mod_sel_t r;
        r = ms;
        if (ms.dup) begin
            r.sect = SECT_BOTH;
        end
        return r;
    endfunction

    // active low one-hot module select
    function automatic logic [MOD_CNT-1:0] mod_sel_n(logic [MOD_W-1:0] mod);
        return ~(MOD_CNT'(1) << mod);
    endfunction

endpackage

// File: common/hop_if.sv
`timescale 1ns/10ps

interface hop_if import lvdc_mem_pkg::*; ();

    hop_field_t load_field;   // assembled serial word
    logic       load_stb;     // load_field valid this cycle
    hop_field_t cur_field;    // stored registers, read back on save
    logic       save_stb;     // shifter samples cur_field this cycle

    modport shifter (
        output load_field,
        output load_stb,
        output save_stb,
        input  cur_field
    );

    modport regs (
        input  load_field,
        input  load_stb,
        output cur_field
    );

endinterface

// File: design/timing_gen.sv
`timescale 1ns/10ps

module timing_gen import lvdc_timing_pkg::*; (
    input  logic   sim_clk,
    input  logic   arst_n,
    output phase_t phase
);

    phase_t phase_q;

    // REI/RED alternation, instruction phase first out of reset
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            phase_q <= PH_INSTR;
        end else begin
            phase_q <= (phase_q == PH_INSTR) ? PH_DATA : PH_INSTR;
        end
    end

    assign phase = phase_q;

endmodule

// File: design/hop_shift.sv
`timescale 1ns/10ps

module hop_shift import lvdc_timing_pkg::*; (
    input  logic   sim_clk,
    input  logic   arst_n,
    input  logic   hop_start,
    input  logic   hop_bit,
    input  logic   hop_save,
    output logic   hopc1,
    output logic   hopc1_valid,
    hop_if.shifter hif
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,   // taking bits 8..0
        ST_SCAP,   // capture registers for save
        ST_SAVE    // shifting out on hopc1
    } state_t;

    state_t               state;
    logic [HOP_BITS-1:0]  shreg;
    logic [HOP_CNT_W-1:0] cnt;
    logic                 load_stb_q;
    logic                 shift_in;

    // bit 9 arrives together with hop_start
    assign shift_in = (state == ST_IDLE && hop_start) || state == ST_LOAD;

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ST_IDLE;
            cnt        <= '0;
            load_stb_q <= 1'b0;
        end else begin
            load_stb_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (hop_start) begin
                        state <= ST_LOAD;
                        cnt   <= HOP_CNT_W'(1);
                    end else if (hop_save) begin
                        state <= ST_SCAP;
                    end
                end
                ST_LOAD: begin
                    if (cnt == HOP_LAST) begin
                        state      <= ST_IDLE;
                        load_stb_q <= 1'b1;   // bit 0 taken on this edge
                    end
                    cnt <= cnt + 1'b1;
                end
                ST_SCAP: begin
                    state <= ST_SAVE;
                    cnt   <= '0;
                end
                ST_SAVE: begin
                    if (cnt == HOP_LAST) begin
                        state <= ST_IDLE;
                    end
                    cnt <= cnt + 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // one register shifts msb first for load and save
    always_ff @(posedge sim_clk) begin
        if (shift_in) begin
            shreg <= {shreg[HOP_BITS-2:0], hop_bit};
        end else if (hif.save_stb) begin
            shreg <= hif.cur_field;
        end else if (state == ST_SAVE) begin
            shreg <= {shreg[HOP_BITS-2:0], 1'b0};
        end
    end

    assign hif.load_field = shreg;
    assign hif.load_stb   = load_stb_q;
    assign hif.save_stb   = (state == ST_SCAP);

    assign hopc1_valid = (state == ST_SAVE);
    assign hopc1       = hopc1_valid & shreg[HOP_BITS-1];

    // load and save requests are mutually exclusive
    a_start_save_excl: assert property (
        @(posedge sim_clk) disable iff (!arst_n) !(hop_start && hop_save)
    );

endmodule

// File: mem_mod_reg/mem_mod_reg.sv
`timescale 1ns/10ps

module mem_mod_reg import lvdc_mem_pkg::*; (
    input  logic     sim_clk,
    input  logic     arst_n,
    hop_if.regs      hif,
    output mod_sel_t im_reg,
    output mod_sel_t dm_reg
);

    mod_sel_t im_q;
    mod_sel_t dm_q;

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            im_q <= MOD_SEL_RST;
            dm_q <= MOD_SEL_RST;
        end else if (hif.load_stb) begin
            im_q <= apply_duplex(hif.load_field.im);   // sect forced at capture
            dm_q <= apply_duplex(hif.load_field.dm);
        end
    end

    assign im_reg = im_q;
    assign dm_reg = dm_q;

    // stored value goes back out on save
    assign hif.cur_field = '{im: im_q, dm: dm_q};

    // some sector is always enabled for either register
    a_sect_nonzero: assert property (
        @(posedge sim_clk) disable iff (!arst_n)
        (im_q.sect != '0) && (dm_q.sect != '0)
    );

endmodule

// File: mem_mod_reg/mem_sel_decode.sv
`timescale 1ns/10ps

module mem_sel_decode import lvdc_timing_pkg::*, lvdc_mem_pkg::*; (
    input  logic     sim_clk,
    input  logic     arst_n,
    input  phase_t   phase,
    input  logic     exm,
    input  mod_sel_t im_reg,
    input  mod_sel_t dm_reg,
    output logic     phase_red,
    output logic     mzon,
    output logic     mttn,
    output logic     mffn,
    output logic     mssn,
    output logic     iman,
    output logic     imbn,
    output logic     dman,
    output logic     dmbn
);

    logic                is_instr;
    logic [MOD_W-1:0]    src_mod;
    logic [MOD_CNT-1:0]  mod_n_q;
    logic [SECT_W-1:0]   im_sect_n_q;
    logic [SECT_W-1:0]   dm_sect_n_q;
    logic                phase_red_q;

    assign is_instr = (phase == PH_INSTR);

    // EXM fetches the word to be modified from the data module
    assign src_mod = (is_instr && !exm) ? im_reg.mod : dm_reg.mod;

    // selects are registered alongside the phase they belong to
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            phase_red_q <= 1'b0;
            mod_n_q     <= '1;
            im_sect_n_q <= '1;
            dm_sect_n_q <= '1;
        end else begin
            phase_red_q <= !is_instr;
            mod_n_q     <= mod_sel_n(src_mod);
            im_sect_n_q <= ~(im_reg.sect & {SECT_W{is_instr}});
            dm_sect_n_q <= ~(dm_reg.sect & {SECT_W{!is_instr}});
        end
    end

    assign phase_red = phase_red_q;
    assign {mssn, mffn, mttn, mzon} = mod_n_q;   // modules 6, 4, 2, 0
    assign {imbn, iman} = im_sect_n_q;
    assign {dmbn, dman} = dm_sect_n_q;

    // once the first decode is out, exactly one module is selected
    a_one_module: assert property (
        @(posedge sim_clk) disable iff (!arst_n)
        $past(arst_n) |-> $onehot(~{mssn, mffn, mttn, mzon})
    );

endmodule

// File: design/lvdc_mem_sel_top.sv
`timescale 1ns/10ps

module lvdc_mem_sel_top import lvdc_timing_pkg::*, lvdc_mem_pkg::*; (
    input  logic sim_clk,
    input  logic arst_n,
    input  logic hop_start,
    input  logic hop_bit,
    input  logic hop_save,
    input  logic exm,
    output logic hopc1,
    output logic hopc1_valid,
    output logic phase_red,
    output logic mzon,
    output logic mttn,
    output logic mffn,
    output logic mssn,
    output logic iman,
    output logic imbn,
    output logic dman,
    output logic dmbn
);

    phase_t   phase;
    mod_sel_t im_reg;
    mod_sel_t dm_reg;

    hop_if hif ();

    timing_gen u_timing_gen (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .phase   (phase)
    );

    hop_shift u_hop_shift (
        .sim_clk     (sim_clk),
        .arst_n      (arst_n),
        .hop_start   (hop_start),
        .hop_bit     (hop_bit),
        .hop_save    (hop_save),
        .hopc1       (hopc1),
        .hopc1_valid (hopc1_valid),
        .hif         (hif.shifter)
    );

    mem_mod_reg u_mem_mod_reg (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .hif     (hif.regs),
        .im_reg  (im_reg),
        .dm_reg  (dm_reg)
    );

    mem_sel_decode u_mem_sel_decode (
        .sim_clk   (sim_clk),
        .arst_n    (arst_n),
        .phase     (phase),
        .exm       (exm),
        .im_reg    (im_reg),
        .dm_reg    (dm_reg),
        .phase_red (phase_red),
        .mzon      (mzon),
        .mttn      (mttn),
        .mffn      (mffn),
        .mssn      (mssn),
        .iman      (iman),
        .imbn      (imbn),
        .dman      (dman),
        .dmbn      (dmbn)
    );

endmodule

// File: tests/tb_model.svh
// expected register contents as the DUT should hold them
mod_sel_t model_im;
mod_sel_t model_dm;
logic     model_exm;   // exm level the decoder samples

task automatic model_reset();
    model_im  = '{mod: 2'd0, sect: 2'b01, dup: 1'b0};   // module 0, sector A
    model_dm  = '{mod: 2'd0, sect: 2'b01, dup: 1'b0};
    model_exm = 1'b0;
endtask

// duplex turns both sectors on when the word is captured
function automatic mod_sel_t model_capture(mod_sel_t ms);
    mod_sel_t r;
    r = ms;
    if (ms.dup) begin
        r.sect = 2'b11;
    end
    return r;
endfunction

task automatic model_load(hop_field_t f);
    model_im = model_capture(f.im);
    model_dm = model_capture(f.dm);
endtask

function automatic hop_field_t model_field();
    return '{im: model_im, dm: model_dm};
endfunction

// module comes from dm in the data phase or under exm, sectors follow the phase
function automatic mod_sel_t model_expect(logic red);
    mod_sel_t e;
    e.dup  = 1'b0;
    e.mod  = (red || model_exm) ? model_dm.mod : model_im.mod;
    e.sect = red ? model_dm.sect : model_im.sect;
    return e;
endfunction

task automatic check_mod_sel(mod_sel_t exp, logic red);
    logic [3:0] exp_mod_n;
    logic [3:0] got_mod_n;
    logic [1:0] exp_i;
    logic [1:0] exp_d;
    exp_mod_n          = 4'b1111;
    exp_mod_n[exp.mod] = 1'b0;
    got_mod_n          = {mssn, mffn, mttn, mzon};
    exp_i              = red ? 2'b11 : ~exp.sect;
    exp_d              = red ? ~exp.sect : 2'b11;
    if (got_mod_n !== exp_mod_n || {imbn, iman} !== exp_i || {dmbn, dman} !== exp_d) begin
        fail_value($sformatf("phase_red %0b: selects %b/%b/%b, expected %b/%b/%b",
            red, got_mod_n, {imbn, iman}, {dmbn, dman}, exp_mod_n, exp_i, exp_d));
    end
endtask

task automatic check_field(hop_field_t got, hop_field_t exp);
    if (got !== exp) begin
        fail_value($sformatf("hopc1 word %03h, expected %03h", got, exp));
    end
endtask

task automatic check_bit(string what, logic got, logic exp);
    if (got !== exp) begin
        fail_value($sformatf("%s is %b, expected %b", what, got, exp));
    end
endtask

task automatic check_count(string what, int got, int exp);
    if (got != exp) begin
        fail_value($sformatf("%s counted %0d, expected %0d", what, got, exp));
    end
endtask

// File: tests/tb_lvdc_mem_sel.sv
`timescale 1ns/10ps

module tb_lvdc_mem_sel import lvdc_timing_pkg::*, lvdc_mem_pkg::*; ();

    logic sim_clk = 1'b0;
    logic arst_n;
    logic hop_start;
    logic hop_bit;
    logic hop_save;
    logic exm;
    logic hopc1;
    logic hopc1_valid;
    logic phase_red;
    logic mzon;
    logic mttn;
    logic mffn;
    logic mssn;
    logic iman;
    logic imbn;
    logic dman;
    logic dmbn;

    lvdc_mem_sel_top dut0 (.*);

    always #5 sim_clk = ~sim_clk;

    task automatic fail_value(string msg);
        $display("ERR %0d ns: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic fail_timeout(string what);
        $display("timed out waiting for %s", what);
        $display("TB FAILED");
        $fatal(1, "stopped on timeout");
    endtask

    `include "tb_model.svh"

    function automatic mod_sel_t rand_mod_sel();
        mod_sel_t r;
        r.mod  = MOD_W'($urandom);
        r.sect = SECT_W'(1 + $urandom % 3);   // 00 would enable no sector
        r.dup  = ($urandom % 4) == 0;
        return r;
    endfunction

    task automatic settle();
        repeat (3) @(posedge sim_clk);
    endtask

    // bit 9 rides with hop_start and a stray hop_save lands mid-frame
    task automatic hop_load(hop_field_t f, int busy_at);
        logic [HOP_BITS-1:0] bits;
        bits = f;
        for (int i = 0; i < HOP_BITS; i++) begin
            @(posedge sim_clk);
            hop_start <= (i == 0);
            hop_save  <= (i == busy_at);
            hop_bit   <= bits[HOP_BITS-1];
            bits = bits << 1;
        end
        @(posedge sim_clk);
        hop_save <= 1'b0;
        hop_bit  <= 1'b0;
    endtask

    task automatic hop_save_check(hop_field_t exp, int busy_at);
        logic [HOP_BITS-1:0] got;
        int n;
        int waited;
        got    = '0;
        n      = 0;
        waited = 0;
        @(posedge sim_clk);
        hop_save <= 1'b1;
        @(posedge sim_clk);
        hop_save <= 1'b0;
        @(negedge sim_clk);
        while (!hopc1_valid) begin
            waited++;
            if (waited > 4) fail_timeout("hopc1_valid after hop_save");
            @(negedge sim_clk);
        end
        while (hopc1_valid) begin
            if (n == HOP_BITS) fail_value("hopc1_valid stays high past the frame");
            got = {got[HOP_BITS-2:0], hopc1};   // msb first
            n++;
            @(posedge sim_clk);
            hop_start <= (n == busy_at);        // shifter is busy and drops it
            @(negedge sim_clk);
        end
        check_count("hopc1_valid cycles", n, HOP_BITS);
        check_field(got, exp);
    endtask

    // scoreboard over a run of cycles with steady inputs
    task automatic check_selects(int cycles);
        logic prev_red;
        @(negedge sim_clk);
        prev_red = ~phase_red;
        repeat (cycles) begin
            check_bit("phase_red alternation", phase_red, ~prev_red);
            prev_red = phase_red;
            check_mod_sel(model_expect(phase_red), phase_red);
            check_bit("hopc1_valid while idle", hopc1_valid, 1'b0);
            @(negedge sim_clk);
        end
    endtask

    task automatic run_load(hop_field_t f);
        hop_load(f, 1 + int'($urandom % 8));
        model_load(f);
        settle();
        check_selects(4);
    endtask

    initial begin
        hop_field_t f;
        void'($urandom(32'h1a211752));
        arst_n    <= 1'b0;
        hop_start <= 1'b0;
        hop_bit   <= 1'b0;
        hop_save  <= 1'b0;
        exm       <= 1'b0;
        model_reset();
        repeat (3) @(posedge sim_clk);
        @(negedge sim_clk);
        check_bit("selects in reset", &{mzon, mttn, mffn, mssn, iman, imbn, dman, dmbn}, 1'b1);
        check_bit("phase_red in reset", phase_red, 1'b0);
        @(posedge sim_clk);
        arst_n <= 1'b1;
        settle();
        check_selects(6);

        // duplex in both halves and the forced sectors read back
        f = '{im: '{mod: 2'd3, sect: 2'b01, dup: 1'b1}, dm: '{mod: 2'd1, sect: 2'b10, dup: 1'b1}};
        run_load(f);
        hop_save_check(model_field(), 1 + int'($urandom % 8));
        check_selects(14);

        for (int op = 0; op < 80; op++) begin
            case ($urandom % 4)
                0: begin
                    f.im = rand_mod_sel();
                    f.dm = rand_mod_sel();
                    run_load(f);
                end
                1: begin
                    hop_save_check(model_field(), 1 + int'($urandom % 8));
                    check_selects(14);   // long enough to see a stray load land
                end
                2: begin
                    @(posedge sim_clk);
                    exm <= ~model_exm;
                    model_exm = ~model_exm;
                    settle();
                    check_selects(4);
                end
                default: begin
                    repeat (1 + $urandom % 5) @(posedge sim_clk);
                    check_selects(2);
                end
            endcase
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: lvdc_mem_sel.f
+incdir+tests
common/lvdc_timing_pkg.sv
common/lvdc_mem_pkg.sv
common/hop_if.sv
design/timing_gen.sv
design/hop_shift.sv
mem_mod_reg/mem_mod_reg.sv
mem_mod_reg/mem_sel_decode.sv
design/lvdc_mem_sel_top.sv
tests/tb_lvdc_mem_sel.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f lvdc_mem_sel.f --top-module tb_lvdc_mem_sel \
    --Mdir obj_dir -o tb_lvdc_mem_sel
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/tb_lvdc_mem_sel)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
